//--- hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// word-addressed sram, 4 KB.
`define RV_MEM_WORDS 1024
`define RV_ADDR_BITS 10

`define RV_RESET_PC 32'h0000_0000

// ebreak, stops the core.
`define RV_EBREAK 32'h0010_0073

`endif

//--- hdl/mem_pkg.sv
package mem_pkg;

  typedef struct packed {
    logic [0  : 0] mem_valid;
    logic [0  : 0] mem_instr;
    logic [31 : 0] mem_addr;   // byte address.
    logic [31 : 0] mem_wdata;
    logic [3  : 0] mem_wstrb;  // nonzero means write.
  } mem_in_type;

  typedef struct packed {
    logic [31 : 0] mem_rdata;
    logic [0  : 0] mem_ready;
  } mem_out_type;

endpackage

//--- hdl/rv_pkg.sv
package rv_pkg;

  typedef enum logic [6 : 0] {
    OPC_LUI    = 7'b0110111,
    OPC_OPIMM  = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_type;

  typedef enum logic [3 : 0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_type;

  typedef struct packed {
    logic [4  : 0] rd;
    logic [4  : 0] rs1;
    logic [4  : 0] rs2;
    logic [31 : 0] imm;
    alu_op_type    alu_op;
    logic [0  : 0] lui;
    logic [0  : 0] opimm;
    logic [0  : 0] op;
    logic [0  : 0] load;
    logic [0  : 0] store;
    logic [0  : 0] branch;
    logic [0  : 0] bne;
    logic [0  : 0] halt;
  } decoder_out_type;

  typedef struct packed {
    logic [4 : 0] rs1;
    logic [4 : 0] rs2;
  } register_read_in_type;

  typedef struct packed {
    logic [0  : 0] wren;
    logic [4  : 0] waddr;
    logic [31 : 0] wdata;
  } register_write_in_type;

  typedef struct packed {
    logic [31 : 0] rdata1;
    logic [31 : 0] rdata2;
  } register_out_type;

  typedef struct packed {
    logic [31 : 0] a;
    logic [31 : 0] b;
    alu_op_type    op;
  } alu_in_type;

  typedef struct packed {
    logic [31 : 0] result;
    logic [0  : 0] equal;
  } alu_out_type;

endpackage

//--- hdl/register.sv
`timescale 1ns/10ps

module register import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  register_read_in_type  register_rin,
  input  register_write_in_type register_win,
  output register_out_type      register_out
);

  logic [31 : 0] regs [1 : 31];  // x0 has no storage.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (register_win.wren && register_win.waddr != 5'd0) begin
      regs[register_win.waddr] <= register_win.wdata;
    end
  end

  always_comb begin
    register_out.rdata1 = '0;
    register_out.rdata2 = '0;
    if (register_rin.rs1 != 5'd0) begin
      register_out.rdata1 = regs[register_rin.rs1];
    end
    if (register_rin.rs2 != 5'd0) begin
      register_out.rdata2 = regs[register_rin.rs2];
    end
  end

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu import rv_pkg::*;
(
  input  alu_in_type  alu_in,
  output alu_out_type alu_out
);

  logic [4 : 0] shamt;

  assign shamt = alu_in.b[4 : 0];

  always_comb begin
    case (alu_in.op)
      ALU_ADD: alu_out.result = alu_in.a + alu_in.b;
      ALU_SUB: alu_out.result = alu_in.a - alu_in.b;
      ALU_AND: alu_out.result = alu_in.a & alu_in.b;
      ALU_OR: alu_out.result = alu_in.a | alu_in.b;
      ALU_XOR: alu_out.result = alu_in.a ^ alu_in.b;
      ALU_SLT: begin
        alu_out.result = {31'b0, $signed(alu_in.a) < $signed(alu_in.b)};
      end
      ALU_SLL: alu_out.result = alu_in.a << shamt;
      ALU_SRL: alu_out.result = alu_in.a >> shamt;
      ALU_SRA: alu_out.result = $signed(alu_in.a) >>> shamt;  // sign fill.
      ALU_PASS_B: alu_out.result = alu_in.b;
      default: alu_out.result = alu_in.a + alu_in.b;
    endcase
    alu_out.equal = (alu_in.a == alu_in.b);  // for beq/bne.
  end

endmodule

//--- hdl/cpu.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module cpu import rv_pkg::*, mem_pkg::*;
(
  input  logic [0 : 0] clk,
  input  logic [0 : 0] rst_n,
  input  logic [0 : 0] run,
  output logic [0 : 0] halt,
  output mem_in_type   imem_in,
  input  mem_out_type  imem_out,
  output mem_in_type   dmem_in,
  input  mem_out_type  dmem_out
);

  typedef enum logic [2 : 0] {
    S_IDLE,
    S_FETCH,
    S_EXECUTE,
    S_MEMORY,
    S_WRITEBACK,
    S_HALT
  } state_type;

  state_type state_q;
  logic [31 : 0] pc_q;
  logic [31 : 0] instr_q;
  logic [31 : 0] result_q;
  logic [31 : 0] pc_next;
  logic [0  : 0] taken;

  decoder_out_type dec;
  register_read_in_type register_rin;
  register_write_in_type register_win;
  register_out_type register_out;
  alu_in_type alu_in;
  alu_out_type alu_out;

  // decoder.
  always_comb begin
    dec = '0;
    dec.rd = instr_q[11 : 7];
    dec.rs1 = instr_q[19 : 15];
    dec.rs2 = instr_q[24 : 20];
    dec.alu_op = ALU_ADD;
    case (opcode_type'(instr_q[6 : 0]))
      OPC_LUI: begin
        dec.lui = 1'b1;
        dec.imm = {instr_q[31 : 12], 12'b0};
        dec.alu_op = ALU_PASS_B;
      end
      OPC_OPIMM: begin
        dec.opimm = (instr_q[14 : 12] == 3'b000);  // addi only.
        dec.halt = !dec.opimm;
        dec.imm = {{20{instr_q[31]}}, instr_q[31 : 20]};
      end
      OPC_OP: begin
        dec.op = 1'b1;
        case ({instr_q[31 : 25], instr_q[14 : 12]})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_111: dec.alu_op = ALU_AND;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          10'b0000000_010: dec.alu_op = ALU_SLT;
          10'b0000000_001: dec.alu_op = ALU_SLL;
          10'b0000000_101: dec.alu_op = ALU_SRL;
          10'b0100000_101: dec.alu_op = ALU_SRA;
          default: begin
            dec.op = 1'b0;
            dec.halt = 1'b1;
          end
        endcase
      end
      OPC_LOAD: begin
        dec.load = (instr_q[14 : 12] == 3'b010);  // lw only.
        dec.halt = !dec.load;
        dec.imm = {{20{instr_q[31]}}, instr_q[31 : 20]};
      end
      OPC_STORE: begin
        dec.store = (instr_q[14 : 12] == 3'b010);
        dec.halt = !dec.store;
        dec.imm = {{20{instr_q[31]}}, instr_q[31 : 25], instr_q[11 : 7]};
      end
      OPC_BRANCH: begin
        dec.branch = (instr_q[14 : 13] == 2'b00);
        dec.bne = instr_q[12];
        dec.halt = !dec.branch;
        dec.imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30 : 25],
                   instr_q[11 : 8], 1'b0};
      end
      default: dec.halt = 1'b1;  // ebreak, or anything unsupported.
    endcase
  end

  always_comb begin
    register_rin.rs1 = dec.rs1;
    register_rin.rs2 = dec.rs2;
    alu_in.a = register_out.rdata1;
    alu_in.b = (dec.op || dec.branch) ? register_out.rdata2 : dec.imm;
    alu_in.op = dec.alu_op;
  end

  assign taken = dec.branch && (alu_out.equal ^ dec.bne);
  assign pc_next = taken ? pc_q + dec.imm : pc_q + 32'd4;

  always_comb begin
    register_win.wren = (state_q == S_WRITEBACK) &&
                        (dec.lui || dec.opimm || dec.op || dec.load);
    register_win.waddr = dec.rd;
    register_win.wdata = result_q;
  end

  register register_comp
  (
    .clk (clk),
    .rst_n (rst_n),
    .register_rin (register_rin),
    .register_win (register_win),
    .register_out (register_out)
  );

  alu alu_comp
  (
    .alu_in (alu_in),
    .alu_out (alu_out)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      pc_q <= `RV_RESET_PC;
      instr_q <= `RV_EBREAK;  // decodes as halt until the first fetch.
    end else begin
      case (state_q)
        S_IDLE: begin
          if (run) begin
            state_q <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (imem_out.mem_ready) begin
            instr_q <= imem_out.mem_rdata;
            state_q <= S_EXECUTE;
          end
        end
        S_EXECUTE: begin
          if (dec.halt) begin
            state_q <= S_HALT;
          end else if (dec.load || dec.store) begin
            state_q <= S_MEMORY;
          end else if (dec.branch) begin
            pc_q <= pc_next;
            state_q <= S_FETCH;
          end else begin
            state_q <= S_WRITEBACK;
          end
        end
        S_MEMORY: begin
          if (dmem_out.mem_ready) begin
            if (dec.load) begin
              state_q <= S_WRITEBACK;
            end else begin
              pc_q <= pc_next;
              state_q <= S_FETCH;
            end
          end
        end
        S_WRITEBACK: begin
          pc_q <= pc_next;
          state_q <= S_FETCH;
        end
        default: state_q <= S_HALT;  // held until reset.
      endcase
    end
  end

  // alu result, later the load data.
  always_ff @(posedge clk) begin
    if (state_q == S_EXECUTE) begin
      result_q <= alu_out.result;
    end else if (state_q == S_MEMORY && dmem_out.mem_ready) begin
      result_q <= dmem_out.mem_rdata;
    end
  end

  always_comb begin
    imem_in.mem_valid = (state_q == S_FETCH);
    imem_in.mem_instr = 1'b1;
    imem_in.mem_addr = pc_q;
    imem_in.mem_wdata = '0;
    imem_in.mem_wstrb = 4'h0;
    dmem_in.mem_valid = (state_q == S_MEMORY);
    dmem_in.mem_instr = 1'b0;
    dmem_in.mem_addr = result_q;
    dmem_in.mem_wdata = register_out.rdata2;
    dmem_in.mem_wstrb = dec.store ? 4'hf : 4'h0;
  end

  assign halt = (state_q == S_HALT);

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter import mem_pkg::*;
(
  input  logic [0 : 0] clk,
  input  logic [0 : 0] rst_n,
  input  mem_in_type   host_in,
  input  mem_in_type   dmem_in,
  input  mem_in_type   imem_in,
  output mem_out_type  host_out,
  output mem_out_type  dmem_out,
  output mem_out_type  imem_out,
  output mem_in_type   mem_in,
  input  mem_out_type  mem_out
);

  typedef enum logic [1 : 0] {
    OWN_NONE,
    OWN_HOST,
    OWN_DATA,
    OWN_INSTR
  } owner_type;

  owner_type owner_q;
  owner_type sel;

  // fixed priority only while idle, then the owner keeps it.
  always_comb begin
    sel = owner_q;
    if (owner_q == OWN_NONE) begin
      if (host_in.mem_valid) begin
        sel = OWN_HOST;
      end else if (dmem_in.mem_valid) begin
        sel = OWN_DATA;
      end else if (imem_in.mem_valid) begin
        sel = OWN_INSTR;
      end
    end
  end

  always_comb begin
    case (sel)
      OWN_HOST: mem_in = host_in;
      OWN_DATA: mem_in = dmem_in;
      OWN_INSTR: mem_in = imem_in;
      default: mem_in = '0;
    endcase
    host_out.mem_rdata = mem_out.mem_rdata;
    host_out.mem_ready = mem_out.mem_ready && (sel == OWN_HOST);
    dmem_out.mem_rdata = mem_out.mem_rdata;
    dmem_out.mem_ready = mem_out.mem_ready && (sel == OWN_DATA);
    imem_out.mem_rdata = mem_out.mem_rdata;
    imem_out.mem_ready = mem_out.mem_ready && (sel == OWN_INSTR);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= OWN_NONE;
    end else if (mem_out.mem_ready) begin
      owner_q <= OWN_NONE;  // free again next cycle.
    end else begin
      owner_q <= sel;
    end
  end

  // a ready only answers a requester that still holds valid.
  a_ready_to_requester: assert property (@(posedge clk) disable iff (!rst_n)
    ({host_out.mem_ready, dmem_out.mem_ready, imem_out.mem_ready} &
     ~{host_in.mem_valid, dmem_in.mem_valid, imem_in.mem_valid}) == 3'b000);

  a_owner_held: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_in.mem_valid && !mem_out.mem_ready) |=> $stable(mem_in));

endmodule

//--- hdl/sram.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module sram import mem_pkg::*;
(
  input  logic [0 : 0] clk,
  input  logic [0 : 0] rst_n,
  input  mem_in_type   mem_in,
  output mem_out_type  mem_out
);

  logic [31 : 0] ram [0 : `RV_MEM_WORDS-1];
  logic [`RV_ADDR_BITS-1 : 0] index;
  logic [31 : 0] rdata_q;
  logic [0  : 0] ready_q;
  logic [0  : 0] access;

  assign index = mem_in.mem_addr[`RV_ADDR_BITS+1 : 2];
  assign access = mem_in.mem_valid && !ready_q;  // idle for a cycle after ready.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_in.mem_wstrb[i]) begin
          ram[index][8*i +: 8] <= mem_in.mem_wdata[8*i +: 8];
        end
      end
      rdata_q <= ram[index];
    end
  end

  assign mem_out = '{mem_rdata: rdata_q, mem_ready: ready_q};

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    mem_in.mem_valid |-> mem_in.mem_addr[31 : 2] < `RV_MEM_WORDS);

  // requester holds its request until ready.
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_in.mem_valid && !mem_out.mem_ready) |=>
      (mem_in.mem_valid && $stable(mem_in.mem_addr)));

endmodule

//--- hdl/soc_top.sv
`timescale 1ns/10ps

module soc_top import mem_pkg::*;
(
  input  logic [0 : 0] clk,
  input  logic [0 : 0] rst_n,
  input  logic [0 : 0] run,
  output logic [0 : 0] halt,
  input  mem_in_type   host_in,
  output mem_out_type  host_out
);

  mem_in_type imem_in;
  mem_out_type imem_out;
  mem_in_type dmem_in;
  mem_out_type dmem_out;
  mem_in_type mem_in;
  mem_out_type mem_out;

  cpu cpu_comp
  (
    .clk (clk),
    .rst_n (rst_n),
    .run (run),
    .halt (halt),
    .imem_in (imem_in),
    .imem_out (imem_out),
    .dmem_in (dmem_in),
    .dmem_out (dmem_out)
  );

  mem_arbiter mem_arbiter_comp
  (
    .clk (clk),
    .rst_n (rst_n),
    .host_in (host_in),
    .dmem_in (dmem_in),
    .imem_in (imem_in),
    .host_out (host_out),
    .dmem_out (dmem_out),
    .imem_out (imem_out),
    .mem_in (mem_in),
    .mem_out (mem_out)
  );

  sram sram_comp
  (
    .clk (clk),
    .rst_n (rst_n),
    .mem_in (mem_in),
    .mem_out (mem_out)
  );

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module tb_checker import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  mem_in_type  host_in,
  input  mem_out_type host_out,
  output int          mismatch_count,
  output int          checked_count
);

  localparam int DUMP_BASE = 768;
  localparam int DUMP_WORDS = 16;
  localparam int STEP_LIMIT = 2000;

  logic [31 : 0] model_mem [0 : `RV_MEM_WORDS-1];
  logic [31 : 0] model_reg [0 : 31];
  logic model_stale = 1'b0;  // program written since the last model run.
  int prog_index = 0;
  int errors = 0;
  int checks = 0;

  assign mismatch_count = errors;
  assign checked_count = checks;

  function automatic logic [`RV_ADDR_BITS-1 : 0] word_of(input logic [31 : 0] addr);
    return addr[`RV_ADDR_BITS+1 : 2];
  endfunction

  // ISA reference, from pc 0 up to ebreak.
  task automatic run_model();
    logic [31 : 0] pc;
    logic [31 : 0] ins;
    logic [31 : 0] a;
    logic [31 : 0] b;
    logic [31 : 0] res;
    logic [31 : 0] imm_i;
    logic [31 : 0] imm_s;
    logic [31 : 0] imm_b;
    logic [31 : 0] next_pc;
    logic wr;
    logic stop;
    int steps;
    for (int i = 0; i < 32; i++) begin
      model_reg[i] = '0;
    end
    pc = '0;
    stop = 1'b0;
    steps = 0;
    while (!stop) begin
      ins = model_mem[word_of(pc)];
      a = model_reg[ins[19 : 15]];
      b = model_reg[ins[24 : 20]];
      imm_i = {{20{ins[31]}}, ins[31 : 20]};
      imm_s = {{20{ins[31]}}, ins[31 : 25], ins[11 : 7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30 : 25], ins[11 : 8], 1'b0};
      res = '0;
      wr = 1'b0;
      next_pc = pc + 32'd4;
      case (ins[6 : 0])
        7'b0110111: begin
          res = {ins[31 : 12], 12'b0};
          wr = 1'b1;
        end
        7'b0010011: begin
          res = a + imm_i;
          wr = (ins[14 : 12] == 3'b000);
          stop = !wr;
        end
        7'b0110011: begin
          wr = 1'b1;
          case ({ins[31 : 25], ins[14 : 12]})
            10'h000: res = a + b;
            10'h100: res = a - b;
            10'h007: res = a & b;
            10'h006: res = a | b;
            10'h004: res = a ^ b;
            10'h002: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            10'h001: res = a << b[4 : 0];
            10'h005: res = a >> b[4 : 0];
            10'h105: res = $unsigned($signed(a) >>> b[4 : 0]);
            default: begin
              wr = 1'b0;
              stop = 1'b1;
            end
          endcase
        end
        7'b0000011: begin
          res = model_mem[word_of(a + imm_i)];
          wr = (ins[14 : 12] == 3'b010);
          stop = !wr;
        end
        7'b0100011: begin
          if (ins[14 : 12] == 3'b010) begin
            model_mem[word_of(a + imm_s)] = b;
          end else begin
            stop = 1'b1;
          end
        end
        7'b1100011: begin
          case (ins[14 : 12])
            3'b000: if (a == b) next_pc = pc + imm_b;
            3'b001: if (a != b) next_pc = pc + imm_b;
            default: stop = 1'b1;
          endcase
        end
        default: stop = 1'b1;  // ebreak lands here.
      endcase
      if (wr && ins[11 : 7] != 5'd0) begin
        model_reg[ins[11 : 7]] = res;
      end
      pc = next_pc;
      steps++;
      if (steps >= STEP_LIMIT && !stop) begin
        $display("reference model never reached ebreak in program %0d", prog_index + 1);
        errors++;
        stop = 1'b1;
      end
    end
  endtask

  task automatic check_dump(input logic [31 : 0] addr, input logic [31 : 0] actual);
    int k;
    string name;
    k = int'(addr[31 : 2]) - DUMP_BASE;
    if (k >= 0 && k < DUMP_WORDS) begin
      name = $sformatf("prog%0d_dump_x%0d", prog_index, k);
      checks++;
      if (actual !== model_reg[k]) begin
        $display("[FAIL] %s expected %08h actual %08h", name, model_reg[k], actual);
        errors++;
      end
    end
  endtask

  // host transfers complete here, mid-cycle.
  always @(negedge clk) begin
    logic [`RV_ADDR_BITS-1 : 0] widx;
    if (rst_n && host_in.mem_valid && host_out.mem_ready) begin
      widx = word_of(host_in.mem_addr);
      if (host_in.mem_wstrb != 4'h0) begin
        for (int i = 0; i < 4; i++) begin
          if (host_in.mem_wstrb[i]) begin
            model_mem[widx][8*i +: 8] = host_in.mem_wdata[8*i +: 8];
          end
        end
        model_stale = 1'b1;
      end else begin
        if (model_stale) begin
          run_model();
          model_stale = 1'b0;
          prog_index++;
        end
        check_dump(host_in.mem_addr, host_out.mem_rdata);
      end
    end
  end

endmodule

//--- sim/tb_top.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module tb_top import mem_pkg::*;
();

  localparam int NUM_PROGS = 3;
  localparam int PROG_WORDS = 64;  // upper bound on program length.
  localparam int DUMP_BASE = 768;
  localparam int DUMP_WORDS = 16;
  localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_WORDS + 40 * 10 + DUMP_WORDS) * 2;

  logic clk = 1'b0;
  logic rst_n;
  logic run;
  logic halt;
  mem_in_type host_in;
  mem_out_type host_out;
  logic [31 : 0] prog [$];
  int cycle_count = 0;
  int flow_errors = 0;
  int check_errors;
  int checked_words;

  always #2 clk = ~clk;

  soc_top DUT (
    .clk (clk),
    .rst_n (rst_n),
    .run (run),
    .halt (halt),
    .host_in (host_in),
    .host_out (host_out)
  );

  tb_checker checker_comp (
    .clk (clk),
    .rst_n (rst_n),
    .host_in (host_in),
    .host_out (host_out),
    .mismatch_count (check_errors),
    .checked_count (checked_words)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing all programs", cycle_count);
      $display("errors: %0d dump mismatches, %0d flow errors", check_errors, flow_errors);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [4 : 0] rand_reg(input int n);
    int r;
    r = $urandom % n;
    return 5'(r);
  endfunction

  function automatic logic [31 : 0] encode_i(input logic [11 : 0] imm, input logic [4 : 0] rs1,
                                             input logic [2 : 0] f3, input logic [4 : 0] rd,
                                             input logic [6 : 0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31 : 0] encode_s(input logic [11 : 0] imm, input logic [4 : 0] rs2,
                                             input logic [4 : 0] rs1);
    return {imm[11 : 5], rs2, rs1, 3'b010, imm[4 : 0], 7'b0100011};
  endfunction

  function automatic logic [31 : 0] encode_b(input logic [12 : 0] off, input logic [4 : 0] rs2,
                                             input logic [4 : 0] rs1, input logic [2 : 0] f3);
    return {off[12], off[10 : 5], rs2, rs1, f3, off[4 : 1], off[11], 7'b1100011};
  endfunction

  // sel picks one of the nine register-register ops.
  function automatic logic [31 : 0] encode_op(input int sel, input logic [4 : 0] rs2,
                                              input logic [4 : 0] rs1, input logic [4 : 0] rd);
    logic [9 : 0] f;
    case (sel)
      0: f = 10'h000;
      1: f = 10'h100;  // sub.
      2: f = 10'h007;
      3: f = 10'h006;
      4: f = 10'h004;
      5: f = 10'h002;
      6: f = 10'h001;
      7: f = 10'h005;
      default: f = 10'h105;  // sra.
    endcase
    return {f[9 : 3], rs2, rs1, f[2 : 0], rd, 7'b0110011};
  endfunction

  task automatic build_program();
    logic [4 : 0] rs1;
    logic [4 : 0] rs2;
    logic [11 : 0] off;
    int kind;
    prog.delete();
    repeat (12) begin
      rs1 = rand_reg(16);
      rs2 = rand_reg(16);
      kind = $urandom % 13;
      case (kind)
        0, 1: prog.push_back({20'($urandom), rand_reg(16), 7'b0110111});
        2, 3: prog.push_back(encode_i(12'($urandom), rs1, 3'b000, rand_reg(16), 7'b0010011));
        default: prog.push_back(encode_op(kind - 4, rs2, rs1, rand_reg(16)));  // rd may be x0.
      endcase
    end
    // x16 = 2048, scratch at word 512.
    prog.push_back(encode_i(12'd1024, 5'd0, 3'b000, 5'd16, 7'b0010011));
    prog.push_back(encode_i(12'd1024, 5'd16, 3'b000, 5'd16, 7'b0010011));
    repeat (3) begin
      off = 12'(($urandom % 8) * 4);
      prog.push_back(encode_s(off, rand_reg(16), 5'd16));
      prog.push_back(encode_i(off, 5'd16, 3'b010, 5'd1 + rand_reg(15), 7'b0000011));
    end
    repeat (4) begin
      rs1 = rand_reg(16);
      rs2 = ($urandom % 2 == 0) ? rs1 : rand_reg(16);
      prog.push_back(encode_b(13'd8, rs2, rs1, ($urandom % 2 == 0) ? 3'b000 : 3'b001));
      prog.push_back(encode_i(12'($urandom), rand_reg(16), 3'b000, 5'd1 + rand_reg(15),
                              7'b0010011));
    end
    prog.push_back(encode_i(12'd1024, 5'd16, 3'b000, 5'd16, 7'b0010011));  // word 768.
    for (int i = 0; i < DUMP_WORDS; i++) begin
      prog.push_back(encode_s(12'(4 * i), 5'(i), 5'd16));
    end
    prog.push_back(`RV_EBREAK);
  endtask

  task automatic host_access(input logic [31 : 0] addr, input logic [31 : 0] wdata,
                             input logic [3 : 0] wstrb);
    mem_in_type req;
    req.mem_valid = 1'b1;
    req.mem_instr = 1'b0;
    req.mem_addr = addr;
    req.mem_wdata = wdata;
    req.mem_wstrb = wstrb;
    @(posedge clk);
    host_in <= req;
    do begin
      @(negedge clk);
    end while (host_out.mem_ready !== 1'b1);
    @(posedge clk);
    host_in <= '0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    run <= 1'b0;
    host_in <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  initial begin
    rst_n = 1'b0;
    run = 1'b0;
    host_in = '0;
    void'($urandom(32'hf3df));
    for (int p = 0; p < NUM_PROGS; p++) begin
      apply_reset();
      build_program();
      for (int i = 0; i < prog.size(); i++) begin
        host_access(32'(4 * i), prog[i], 4'hf);
        @(negedge clk);
        if (halt !== 1'b0) begin
          $display("halt went high before run in program %0d", p + 1);
          flow_errors++;
        end
      end
      @(posedge clk);
      run <= 1'b1;
      do begin
        @(negedge clk);
      end while (halt !== 1'b1);
      for (int i = 0; i < DUMP_WORDS; i++) begin
        host_access(32'(4 * (DUMP_BASE + i)), 32'h0, 4'h0);
      end
    end
    if (checked_words != NUM_PROGS * DUMP_WORDS) begin
      $display("only %0d of %0d dump words were compared", checked_words,
               NUM_PROGS * DUMP_WORDS);
      flow_errors++;
    end
    $display("errors: %0d dump mismatches, %0d flow errors", check_errors, flow_errors);
    if (check_errors == 0 && flow_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/rv_pkg.sv
hdl/register.sv
hdl/alu.sv
hdl/cpu.sv
hdl/mem_arbiter.sv
hdl/sram.sv
hdl/soc_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_top with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
